// ==== cache_pkg.sv ====
package cache_pkg;

  //----------------------------------------------------------------------
  // Cache geometry
  //----------------------------------------------------------------------

  localparam int ADDR_W         = 16;                     // Word address
  localparam int DATA_W         = 32;
  localparam int NUM_SETS       = 8;
  localparam int WORDS_PER_LINE = 4;

  localparam int INDEX_W  = $clog2(NUM_SETS);
  localparam int OFFSET_W = $clog2(WORDS_PER_LINE);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  //----------------------------------------------------------------------
  // Request types, shared by processor and memory channels
  //----------------------------------------------------------------------

  localparam logic REQ_READ  = 1'b0;
  localparam logic REQ_WRITE = 1'b1;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic                way_t;

  // Pipe is the normal hit path, spill and refill serve a miss
  typedef enum logic [1:0] {
    STATE_PIPE,
    STATE_SPILL,
    STATE_REFILL
  } cache_state_t;

endpackage

// ==== ctrl_dpath_if.sv ====
`timescale 1ns/1ps

interface ctrl_dpath_if;

  // Control, driven by the control unit
  logic req_en;                                           // Load Y request into M0
  logic lookup_en;                                        // M0 valid in pipe state
  logic darray_wen;
  logic tarray_wen;                                       // Tag, valid write at refill end
  logic refill_sel;                                       // Data array source is memory
  logic spill_sel;                                        // Memory address from victim
  logic word_sent;
  logic word_received;

  // Status, driven by the datapath
  logic tag_match;
  logic victim_dirty;
  logic spill_done;
  logic refill_req_done;
  logic refill_resp_done;

  modport ctrl (
    output req_en, lookup_en, darray_wen, tarray_wen,
    output refill_sel, spill_sel, word_sent, word_received,
    input  tag_match, victim_dirty, spill_done, refill_req_done, refill_resp_done
  );

  modport dpath (
    input  req_en, lookup_en, darray_wen, tarray_wen,
    input  refill_sel, spill_sel, word_sent, word_received,
    output tag_match, victim_dirty, spill_done, refill_req_done, refill_resp_done
  );

endinterface

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl
  import cache_pkg::*;
(
  input  logic clk,
  input  logic reset,

  // Processor side
  input  logic memreq_val,
  input  logic memreq_type,
  output logic memreq_rdy,

  output logic memresp_val,
  input  logic memresp_rdy,
  output logic memresp_type,

  // Memory side
  output logic mem_req_val,
  input  logic mem_req_rdy,
  output logic mem_req_type,

  input  logic mem_resp_val,
  output logic mem_resp_rdy,

  ctrl_dpath_if.ctrl ctl
);

  //----------------------------------------------------------------------
  // M0 stage
  //----------------------------------------------------------------------

  logic val_m0;
  logic type_m0;
  logic stall_m0;

  // Stall on a miss or when the processor is not taking the response
  assign stall_m0   = val_m0 && (!ctl.tag_match || !memresp_rdy);
  assign memreq_rdy = !stall_m0;
  assign ctl.req_en = memreq_val && memreq_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_m0 <= 1'b0;
    end else if (ctl.req_en) begin
      val_m0 <= 1'b1;
    end else if (!stall_m0) begin
      val_m0 <= 1'b0;                                     // Retired, nothing behind it
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      type_m0 <= REQ_READ;
    end else if (ctl.req_en) begin
      type_m0 <= memreq_type;
    end
  end

  //----------------------------------------------------------------------
  // Miss handling FSM
  //----------------------------------------------------------------------

  cache_state_t state;
  cache_state_t state_next;
  logic         in_pipe;
  logic         in_spill;
  logic         in_refill;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= STATE_PIPE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      STATE_PIPE: begin
        if (val_m0 && !ctl.tag_match) begin
          state_next = ctl.victim_dirty ? STATE_SPILL : STATE_REFILL;
        end
      end
      STATE_SPILL: begin
        if (ctl.spill_done) state_next = STATE_REFILL;   // Whole victim line written
      end
      STATE_REFILL: begin
        if (ctl.refill_resp_done) state_next = STATE_PIPE;
      end
      default: state_next = STATE_PIPE;
    endcase
  end

  assign in_pipe   = (state == STATE_PIPE);
  assign in_spill  = (state == STATE_SPILL);
  assign in_refill = (state == STATE_REFILL);

  //----------------------------------------------------------------------
  // Outputs
  //----------------------------------------------------------------------

  assign ctl.lookup_en = in_pipe && val_m0;
  assign memresp_val   = ctl.lookup_en && ctl.tag_match;
  assign memresp_type  = type_m0;

  // Write hit keeps writing the same word while the response waits
  assign ctl.darray_wen = (memresp_val && (type_m0 == REQ_WRITE)) ||
                          (in_refill && ctl.word_received);
  assign ctl.tarray_wen = in_refill && ctl.refill_resp_done;
  assign ctl.refill_sel = in_refill;
  assign ctl.spill_sel  = in_spill;

  assign mem_req_val  = (in_spill && !ctl.spill_done) ||
                        (in_refill && !ctl.refill_req_done);
  assign mem_req_type = in_spill ? REQ_WRITE : REQ_READ;
  assign mem_resp_rdy = in_refill;                        // Only reads come back

  assign ctl.word_sent     = mem_req_val && mem_req_rdy;
  assign ctl.word_received = mem_resp_val && mem_resp_rdy;

  // A memory request waits with its type until the memory takes it
  a_mem_req_held: assert property (
    @(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_type)
  );

  // The held request hits right after its line is refilled
  a_hit_after_refill: assert property (
    @(posedge clk) disable iff (reset) ctl.tarray_wen |=> memresp_val
  );

endmodule

// ==== cache_dpath.sv ====
`timescale 1ns/1ps

module cache_dpath
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  reset,

  input  addr_t memreq_addr,
  input  data_t memreq_data,
  output data_t memresp_data,

  output addr_t mem_req_addr,
  output data_t mem_req_data,
  input  data_t mem_resp_data,

  ctrl_dpath_if.dpath dp
);

  //----------------------------------------------------------------------
  // M0 request registers
  //----------------------------------------------------------------------

  addr_t   addr_m0;
  data_t   data_m0;
  tag_t    tag_m0;
  index_t  index_m0;
  offset_t offset_m0;

  always_ff @(posedge clk) begin
    if (dp.req_en) begin
      addr_m0 <= memreq_addr;
      data_m0 <= memreq_data;
    end
  end

  assign tag_m0    = addr_m0[ADDR_W-1 -: TAG_W];
  assign index_m0  = addr_m0[OFFSET_W +: INDEX_W];
  assign offset_m0 = addr_m0[OFFSET_W-1:0];

  //----------------------------------------------------------------------
  // Tag, valid, dirty and LRU state
  //----------------------------------------------------------------------

  tag_t tag_array   [2][NUM_SETS];
  logic valid_array [2][NUM_SETS];
  logic dirty_array [2][NUM_SETS];
  way_t lru_array   [NUM_SETS];                           // Way to replace next

  logic way0_hit;
  logic way1_hit;
  way_t hit_way;
  way_t victim_way;
  way_t sel_way;
  tag_t victim_tag;

  assign way0_hit   = valid_array[0][index_m0] && (tag_array[0][index_m0] == tag_m0);
  assign way1_hit   = valid_array[1][index_m0] && (tag_array[1][index_m0] == tag_m0);
  assign hit_way    = way1_hit;
  assign victim_way = lru_array[index_m0];
  assign sel_way    = (way0_hit || way1_hit) ? hit_way : victim_way;
  assign victim_tag = tag_array[victim_way][index_m0];

  assign dp.tag_match    = dp.lookup_en && (way0_hit || way1_hit);
  assign dp.victim_dirty = valid_array[victim_way][index_m0] &&
                           dirty_array[victim_way][index_m0];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < 2; w++) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          valid_array[w][s] <= 1'b0;
          dirty_array[w][s] <= 1'b0;
        end
      end
      for (int s = 0; s < NUM_SETS; s++) begin
        lru_array[s] <= 1'b0;
      end
    end else begin
      if (dp.tarray_wen) begin
        valid_array[victim_way][index_m0] <= 1'b1;
        dirty_array[victim_way][index_m0] <= 1'b0;        // Fresh line from memory
      end
      if (dp.darray_wen && !dp.refill_sel) begin
        dirty_array[sel_way][index_m0] <= 1'b1;           // Write hit
      end
      if (dp.tag_match) begin
        lru_array[index_m0] <= ~hit_way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dp.tarray_wen) begin
      tag_array[victim_way][index_m0] <= tag_m0;
    end
  end

  //----------------------------------------------------------------------
  // Word counters for spill and refill
  //----------------------------------------------------------------------

  logic [OFFSET_W:0] spill_cnt;                           // Top bit marks a full line
  logic [OFFSET_W:0] req_cnt;
  offset_t           resp_cnt;

  always_ff @(posedge clk) begin
    if (reset || dp.tarray_wen) begin
      spill_cnt <= '0;
      req_cnt   <= '0;
      resp_cnt  <= '0;
    end else begin
      if (dp.word_sent && dp.spill_sel) spill_cnt <= spill_cnt + 1'b1;
      if (dp.word_sent && !dp.spill_sel) req_cnt <= req_cnt + 1'b1;
      if (dp.word_received) resp_cnt <= resp_cnt + 1'b1;
    end
  end

  assign dp.spill_done       = spill_cnt[OFFSET_W];
  assign dp.refill_req_done  = req_cnt[OFFSET_W];
  // Last word arriving ends the refill on the same edge
  assign dp.refill_resp_done = dp.word_received && (resp_cnt == offset_t'(WORDS_PER_LINE - 1));

  assign mem_req_addr = dp.spill_sel ?
                        {victim_tag, index_m0, spill_cnt[OFFSET_W-1:0]} :
                        {tag_m0, index_m0, req_cnt[OFFSET_W-1:0]};

  //----------------------------------------------------------------------
  // Data arrays
  //----------------------------------------------------------------------

  data_t   data_array [2][NUM_SETS][WORDS_PER_LINE];
  offset_t wr_offset;
  data_t   wr_data;

  assign wr_offset = dp.refill_sel ? resp_cnt : offset_m0;
  assign wr_data   = dp.refill_sel ? mem_resp_data : data_m0;

  always_ff @(posedge clk) begin
    if (dp.darray_wen) begin
      data_array[sel_way][index_m0][wr_offset] <= wr_data;
    end
  end

  assign mem_req_data = data_array[victim_way][index_m0][spill_cnt[OFFSET_W-1:0]];

  // Write responses carry no data
  assign memresp_data = (dp.darray_wen && !dp.refill_sel) ? '0 :
                        data_array[sel_way][index_m0][offset_m0];

  // A line lives in at most one way of its set
  a_single_way_hit: assert property (
    @(posedge clk) disable iff (reset) !(way0_hit && way1_hit)
  );

endmodule

// ==== two_way_cache.sv ====
`timescale 1ns/1ps

module two_way_cache
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  reset,

  // Processor request
  input  logic  memreq_val,
  output logic  memreq_rdy,
  input  logic  memreq_type,
  input  addr_t memreq_addr,
  input  data_t memreq_data,

  // Processor response
  output logic  memresp_val,
  input  logic  memresp_rdy,
  output logic  memresp_type,
  output data_t memresp_data,

  // Memory request
  output logic  mem_req_val,
  input  logic  mem_req_rdy,
  output logic  mem_req_type,
  output addr_t mem_req_addr,
  output data_t mem_req_data,

  // Memory response
  input  logic  mem_resp_val,
  output logic  mem_resp_rdy,
  input  data_t mem_resp_data
);

  ctrl_dpath_if ctl_dp ();

  cache_ctrl ctrl (
    .clk          (clk),
    .reset        (reset),
    .memreq_val   (memreq_val),
    .memreq_type  (memreq_type),
    .memreq_rdy   (memreq_rdy),
    .memresp_val  (memresp_val),
    .memresp_rdy  (memresp_rdy),
    .memresp_type (memresp_type),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req_type (mem_req_type),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .ctl          (ctl_dp.ctrl)
  );

  cache_dpath dpath (
    .clk           (clk),
    .reset         (reset),
    .memreq_addr   (memreq_addr),
    .memreq_data   (memreq_data),
    .memresp_data  (memresp_data),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .mem_resp_data (mem_resp_data),
    .dp            (ctl_dp.dpath)
  );

endmodule

// ==== tb_two_way_cache.sv ====
`timescale 1ns/1ps

module tb_two_way_cache
  import cache_pkg::*;
();

  localparam int          CLK_PERIOD      = 100;
  localparam int          NUM_REQS        = 351;                  // All phases together
  localparam int          WATCHDOG_CYCLES = NUM_REQS * 200 + 1000;
  localparam int          DRAIN_CYCLES    = 1000;                 // Longest wait for responses
  localparam logic [31:0] SEED            = 32'ha1e5e5b9;
  localparam data_t       FILL_PATTERN    = 32'h5a3c_96e1;

  logic  clk, reset;
  logic  memreq_val, memreq_rdy, memreq_type;
  addr_t memreq_addr;
  data_t memreq_data;
  logic  memresp_val, memresp_rdy, memresp_type;
  data_t memresp_data;
  logic  mem_req_val, mem_req_rdy, mem_req_type;
  addr_t mem_req_addr;
  data_t mem_req_data;
  logic  mem_resp_val, mem_resp_rdy;
  data_t mem_resp_data;

  data_t       mem     [2**ADDR_W];
  data_t       shadow  [2**ADDR_W];                             // Processor view of memory
  logic        written [2**ADDR_W];
  logic        exp_type_q [$];
  data_t       exp_data_q [$];
  addr_t       pend_addr_q [$];                                 // Reads waiting for a response
  int          pend_ready_q [$];
  int          error_count;
  logic        rand_resp_rdy;
  logic [31:0] stim_seed;

  two_way_cache UUT (.*);

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic data_t init_word(input addr_t a);
    return data_t'(a) ^ FILL_PATTERN;
  endfunction

  function automatic data_t expected_read(input addr_t a);
    return written[a] ? shadow[a] : init_word(a);
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the cache stopped responding", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  //--------------------------------------------------------------------
  // Memory model, also drives memresp_rdy
  //--------------------------------------------------------------------

  initial begin : memory_model
    logic [31:0] seed;
    logic        req_fire;
    logic        resp_fire;
    logic        req_type;
    addr_t       req_addr;
    data_t       req_data;
    int          cycle;
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mem[a]     = init_word(addr_t'(a));
      written[a] = 1'b0;
    end
    seed          = SEED;
    cycle         = 0;
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_data = '0;
    memresp_rdy   = 1'b1;
    forever begin
      @(negedge clk);
      req_fire  = mem_req_val && mem_req_rdy;                   // Transfers on the next edge
      resp_fire = mem_resp_val && mem_resp_rdy;
      req_type  = mem_req_type;
      req_addr  = mem_req_addr;
      req_data  = mem_req_data;
      @(posedge clk);
      #1;
      cycle++;
      seed = lcg_next(seed);
      if (resp_fire) begin
        void'(pend_addr_q.pop_front());
        void'(pend_ready_q.pop_front());
      end
      if (req_fire && req_type == REQ_WRITE) begin
        if (req_data !== expected_read(req_addr)) begin
          $display("** Error @ %0t: spill to %h wrote %h, expected %h",
                   $time, req_addr, req_data, expected_read(req_addr));
          error_count++;
        end
        mem[req_addr] = req_data;
      end else if (req_fire) begin
        pend_addr_q.push_back(req_addr);
        pend_ready_q.push_back(cycle + 1 + int'(seed[25:24]));  // Random read latency
      end
      mem_req_rdy = (seed[31:29] != 3'd0);
      memresp_rdy = !rand_resp_rdy || (seed[28:27] != 2'd0);
      if (pend_addr_q.size() > 0 && cycle >= pend_ready_q[0]) begin
        mem_resp_val  = 1'b1;
        mem_resp_data = mem[pend_addr_q[0]];
      end else begin
        mem_resp_val  = 1'b0;
        mem_resp_data = '0;
      end
    end
  end

  //--------------------------------------------------------------------
  // Response checker
  //--------------------------------------------------------------------

  initial begin : response_checker
    logic  held;
    logic  held_type;
    data_t held_data;
    logic  exp_type;
    data_t exp_data;
    held = 1'b0;
    forever begin
      @(negedge clk);
      if (!reset) begin
        if (held && (!memresp_val || memresp_type !== held_type ||
                     memresp_data !== held_data)) begin
          $display("** Error @ %0t: stalled response changed to val %b type %b data %h",
                   $time, memresp_val, memresp_type, memresp_data);
          error_count++;
        end
        if (memresp_val && memresp_rdy && exp_type_q.size() == 0) begin
          $display("Response at %0t arrived with no request outstanding", $time);
          error_count++;
        end else if (memresp_val && memresp_rdy) begin
          exp_type = exp_type_q.pop_front();
          exp_data = exp_data_q.pop_front();
          if (memresp_type !== exp_type || memresp_data !== exp_data) begin
            $display("** Error @ %0t: response expected type %b data %h, got type %b data %h",
                     $time, exp_type, exp_data, memresp_type, memresp_data);
            error_count++;
          end
        end
        held      = memresp_val && !memresp_rdy;
        held_type = memresp_type;
        held_data = memresp_data;
        if (memreq_val && memreq_rdy) begin
          exp_type_q.push_back(memreq_type);
          if (memreq_type == REQ_WRITE) begin
            shadow[memreq_addr]  = memreq_data;
            written[memreq_addr] = 1'b1;
            exp_data_q.push_back('0);                           // Write responses carry no data
          end else begin
            exp_data_q.push_back(expected_read(memreq_addr));
          end
        end
      end
    end
  end

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------

  task automatic send_request(input logic typ, input addr_t addr, input data_t data);
    logic fire;
    memreq_val  = 1'b1;
    memreq_type = typ;
    memreq_addr = addr;
    memreq_data = data;
    fire        = 1'b0;
    while (!fire) begin
      @(negedge clk);
      fire = memreq_val && memreq_rdy;
      @(posedge clk);
      #1;
    end
    memreq_val = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_type_q.size() != 0 && cycles < DRAIN_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  initial begin : stimulus
    logic [31:0] r;
    reset         = 1'b1;
    memreq_val    = 1'b0;
    memreq_type   = REQ_READ;
    memreq_addr   = '0;
    memreq_data   = '0;
    error_count   = 0;
    rand_resp_rdy = 1'b0;
    stim_seed     = SEED;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    if (memreq_rdy !== 1'b1 || memresp_val !== 1'b0 || mem_req_val !== 1'b0 ||
        mem_resp_rdy !== 1'b0) begin
      $display("** Error @ %0t: idle outputs after reset rdy %b resp %b mreq %b mresp_rdy %b",
               $time, memreq_rdy, memresp_val, mem_req_val, mem_resp_rdy);
      error_count++;
    end
    @(posedge clk);
    #1;
    send_request(REQ_READ, 16'h0123, '0);                       // Clean refill
    send_request(REQ_WRITE, 16'h0040, 32'hcafe_f00d);
    send_request(REQ_READ, 16'h0040, '0);
    wait_drain();
    // Three lines in set 5 force dirty evictions
    for (int line = 0; line < 6; line++) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        stim_seed = lcg_next(stim_seed);
        send_request(line < 3 ? REQ_WRITE : REQ_READ,
                     {tag_t'(16 + line % 3), index_t'(5), offset_t'(w)}, stim_seed);
      end
    end
    wait_drain();
    rand_resp_rdy = 1'b1;
    for (int i = 0; i < 24; i++) begin
      stim_seed = lcg_next(stim_seed);
      send_request(~i[0], addr_t'(16'h0040 + i / 2), stim_seed);
    end
    for (int i = 0; i < 300; i++) begin
      stim_seed = lcg_next(stim_seed);
      r         = stim_seed;
      stim_seed = lcg_next(stim_seed);
      send_request(r[31], addr_t'(r[30:24]), stim_seed);
    end
    wait_drain();
    repeat (4) @(posedge clk);
    if (exp_type_q.size() != 0) begin
      $display("%0d responses never arrived", exp_type_q.size());
      error_count++;
    end
    $display("Simulation finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== two_way_cache.f ====
cache_pkg.sv
ctrl_dpath_if.sv
cache_ctrl.sv
cache_dpath.sv
two_way_cache.sv
tb_two_way_cache.sv

// ==== Makefile ====
TOP := tb_two_way_cache

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): two_way_cache.f $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f two_way_cache.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then echo "Simulation ended early"; exit 1; fi

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f two_way_cache.f

clean:
	rm -rf obj_dir sim.log
